// ==== hw/pe_cfg.svh ====
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define PE_DATA_W   64   // Vector register and memory word
`define PE_ADDR_W   32   // Instruction and data address
`define PE_REG_AW   5    // 32 registers
`define PE_IMM_W    16   // Load/store/branch immediate

// ------------------------------
// Fetch
// ------------------------------
`define PE_PC_STEP  4    // Byte step between instructions

`endif

// ==== hw/pe_pkg.sv ====
`include "pe_cfg.svh"

package pe_pkg;

    // ------------------------------
    // Instruction encodings
    // ------------------------------
    typedef enum logic [0:5] {
        OP_RTYPE = 6'b101010,
        OP_LOAD  = 6'b100000,
        OP_STORE = 6'b100001,
        OP_BEZ   = 6'b100010,
        OP_BNEZ  = 6'b100011,
        OP_NOP   = 6'b111100
    } opcode_t;

    typedef enum logic [0:5] {
        FN_AND = 6'b000001,
        FN_OR  = 6'b000010,
        FN_XOR = 6'b000011,
        FN_NOT = 6'b000100,
        FN_MOV = 6'b000101,
        FN_ADD = 6'b000110,
        FN_SUB = 6'b000111
    } func_t;

    typedef enum logic [0:2] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_XOR = 3'b010,
        ALU_NOT = 3'b011,
        ALU_ADD = 3'b100,
        ALU_SUB = 3'b101
    } alu_op_t;

    typedef enum logic [0:1] {
        LANE_B = 2'b00,  // 8 x byte
        LANE_H = 2'b01,  // 4 x half-word
        LANE_W = 2'b10,  // 2 x word
        LANE_D = 2'b11   // Whole register
    } lane_w_t;

    // Codes 101..111 are legal in the word and write nothing
    typedef enum logic [0:2] {
        PREC_ALL  = 3'b000,
        PREC_HI   = 3'b001,  // Bits 0-31, leftmost word
        PREC_LO   = 3'b010,  // Bits 32-63
        PREC_EVEN = 3'b011,  // Byte lanes 0, 2, 4, 6
        PREC_ODD  = 3'b100   // Byte lanes 1, 3, 5, 7
    } wr_prec_t;

    typedef enum logic [0:2] {
        PATH_NONE = 3'b000,
        PATH_ALU  = 3'b001,
        PATH_MOV  = 3'b101
    } ex_path_t;

    // ------------------------------
    // Instruction word, two views
    // ------------------------------
    typedef struct packed {
        opcode_t               opcode;
        logic [0:`PE_REG_AW-1] rd;
        logic [0:`PE_REG_AW-1] ra;
        logic [0:`PE_REG_AW-1] rb;
        wr_prec_t              prec;
        lane_w_t               lane_w;
        func_t                 func;
    } r_fmt_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [0:`PE_REG_AW-1] rd;   // Destination, or source for store/branch
        logic [0:`PE_REG_AW-1] ra;
        logic [0:`PE_IMM_W-1]  imm;  // Memory address or branch target
    } m_fmt_t;

    typedef union packed {
        r_fmt_t r;
        m_fmt_t m;
    } instr_u;

    // Bit mask of the byte lanes a precision code touches
    function automatic logic [0:`PE_DATA_W-1] wr_mask(input wr_prec_t p);
        case (p)
            PREC_ALL:  return '1;
            PREC_HI:   return {{32{1'b1}}, {32{1'b0}}};
            PREC_LO:   return {{32{1'b0}}, {32{1'b1}}};
            PREC_EVEN: return {4{8'hff, 8'h00}};
            PREC_ODD:  return {4{8'h00, 8'hff}};
            default:   return '0;  // Unused code, register untouched
        endcase
    endfunction

endpackage

// ==== hw/pe_if.sv ====
`timescale 1ns/1ps
`include "pe_cfg.svh"

// Write-back bundle, EX/WB register out to the register file
interface wb_if import pe_pkg::*; ();
    logic                  reg_wr;  // Write strobe
    logic [0:`PE_REG_AW-1] wa;      // Destination register
    logic [0:`PE_DATA_W-1] wd;      // Result word
    wr_prec_t              ppp;     // Partial write select

    modport src  (output reg_wr, wa, wd, ppp);
    modport sink (input  reg_wr, wa, wd, ppp);
endinterface

// ID/EX control register, decoder side to execute side
interface ex_ctrl_if import pe_pkg::*; ();
    logic                  reg_wr;
    logic [0:`PE_REG_AW-1] rd;
    wr_prec_t              ppp;
    lane_w_t               lane_w;
    alu_op_t               alu_op;
    ex_path_t              path;
    logic                  load;
    logic                  store;
    logic                  is_branch;
    logic                  branch_nz;  // bnez when set, bez otherwise
    logic [0:`PE_REG_AW-1] rs_a;       // Source addresses for EX forwarding
    logic [0:`PE_REG_AW-1] rt_a;

    modport ctrl (output reg_wr, rd, ppp, lane_w, alu_op, path, load, store,
                  is_branch, branch_nz, rs_a, rt_a);
    modport exec (input  reg_wr, rd, ppp, lane_w, alu_op, path, load, store,
                  is_branch, branch_nz, rs_a, rt_a);
endinterface

// ==== hw/pe_vec_alu.sv ====
`timescale 1ns/1ps
`include "pe_cfg.svh"

module pe_vec_alu import pe_pkg::*; (
    input  alu_op_t               alu_op,
    input  lane_w_t               lane_w,
    input  logic [0:`PE_DATA_W-1] a,
    input  logic [0:`PE_DATA_W-1] b,
    output logic [0:`PE_DATA_W-1] y
);

    localparam int NBYTE = `PE_DATA_W / 8;

    logic [0:`PE_DATA_W-1] sum;   // Lane-wise a+b or a-b
    logic                  is_sub;

    assign is_sub = (alu_op == ALU_SUB);

    // ------------------------------
    // Byte-sliced adder
    // ------------------------------
    // Carry ripples from byte 7 (rightmost) toward byte 0 and is cut
    // at each lane start; subtract is a + ~b + 1 per lane
    always_comb begin : lane_adder
        logic       carry;
        logic [7:0] bb;
        logic [8:0] s9;
        int         lane_bytes;
        lane_bytes = 1 << lane_w;  // 1, 2, 4 or 8 bytes per lane
        carry      = is_sub;
        for (int i = NBYTE - 1; i >= 0; i--) begin
            bb = is_sub ? ~b[8*i +: 8] : b[8*i +: 8];
            s9 = {1'b0, a[8*i +: 8]} + {1'b0, bb} + {8'd0, carry};
            sum[8*i +: 8] = s9[7:0];
            // Carry stays inside the lane unless byte i starts it
            carry = ((i & (lane_bytes - 1)) != 0) ? s9[8] : is_sub;
        end
    end

    always_comb begin
        case (alu_op)
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_NOT: y = ~a;        // Second operand ignored
            ALU_ADD, ALU_SUB: y = sum;  // Lane adder covers both
            default: y = '0;
        endcase
    end

endmodule

// ==== hw/pe_regfile.sv ====
`timescale 1ns/1ps
`include "pe_cfg.svh"

module pe_regfile import pe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [0:`PE_REG_AW-1] ra1,
    input  logic [0:`PE_REG_AW-1] ra2,
    output logic [0:`PE_DATA_W-1] rd1,
    output logic [0:`PE_DATA_W-1] rd2,
    wb_if.sink                    wb
);

    localparam int NREG = 1 << `PE_REG_AW;

    logic [0:`PE_DATA_W-1] regs [0:NREG-1];
    logic [0:`PE_DATA_W-1] wmask;  // Lanes touched by the WB write

    assign wmask = wr_mask(wb.ppp);

    // Write at the WB edge, r0 stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREG; i++)
                regs[i] <= '0;
        end else if (wb.reg_wr && wb.wa != '0) begin
            regs[wb.wa] <= (regs[wb.wa] & ~wmask) | (wb.wd & wmask);
        end
    end

    // Reads see the WB value in the same cycle, merged lane by lane
    always_comb begin
        rd1 = regs[ra1];
        if (wb.reg_wr && ra1 == wb.wa)
            rd1 = (rd1 & ~wmask) | (wb.wd & wmask);
        if (ra1 == '0)
            rd1 = '0;
        rd2 = regs[ra2];
        if (wb.reg_wr && ra2 == wb.wa)
            rd2 = (rd2 & ~wmask) | (wb.wd & wmask);
        if (ra2 == '0)
            rd2 = '0;
    end

endmodule

// ==== hw/pe_ctrl.sv ====
`timescale 1ns/1ps
`include "pe_cfg.svh"

module pe_ctrl import pe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  instr_u                instr,       // Fetched word, combinational
    input  logic                  rs_zero,     // EX first operand is zero
    input  logic [0:`PE_IMM_W-1]  imm,         // EX immediate, branch target
    output logic [0:`PE_ADDR_W-1] instr_addr,
    output logic [0:`PE_REG_AW-1] ra1,
    output logic [0:`PE_REG_AW-1] ra2,
    output logic [0:`PE_IMM_W-1]  imm_id,      // ID immediate into ID/EX
    output logic                  stall,
    output logic                  taken,
    ex_ctrl_if.ctrl               ctrl
);

    logic [0:`PE_ADDR_W-1] pc_q;
    instr_u                ifid_q;
    logic                  ifid_flush_q;  // IF/ID holds a bubble
    logic                  stalled_q;     // Load stall was taken last cycle
    logic                  kill;
    logic                  dec_reg_wr;
    logic                  dec_load;
    logic                  dec_store;
    logic                  dec_branch;
    logic                  dec_nz;
    alu_op_t               dec_alu_op;
    ex_path_t              dec_path;
    wr_prec_t              dec_ppp;

    assign instr_addr = pc_q;

    // Load holds the pipe once, data is back the next cycle
    assign stall = ctrl.load && !stalled_q;
    assign taken = ctrl.is_branch && (ctrl.branch_nz ? !rs_zero : rs_zero);
    assign kill  = ifid_flush_q || taken;  // Squash the word in ID

    // ------------------------------
    // PC and IF/ID
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q         <= '0;
            ifid_flush_q <= 1'b1;
            stalled_q    <= 1'b0;
        end else begin
            stalled_q <= stall;
            if (!stall) begin
                pc_q <= taken ? {{(`PE_ADDR_W-`PE_IMM_W){1'b0}}, imm}
                              : pc_q + `PE_PC_STEP;
                ifid_flush_q <= taken;  // Word being fetched is a shadow
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            ifid_q <= instr;
    end

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        dec_reg_wr = 1'b0;
        dec_load   = 1'b0;
        dec_store  = 1'b0;
        dec_branch = 1'b0;
        dec_nz     = 1'b0;
        dec_alu_op = ALU_AND;
        dec_path   = PATH_NONE;
        dec_ppp    = ifid_q.r.prec;
        case (ifid_q.r.opcode)
            OP_RTYPE: begin
                dec_reg_wr = 1'b1;
                dec_path   = PATH_ALU;
                case (ifid_q.r.func)
                    FN_AND: dec_alu_op = ALU_AND;
                    FN_OR:  dec_alu_op = ALU_OR;
                    FN_XOR: dec_alu_op = ALU_XOR;
                    FN_NOT: dec_alu_op = ALU_NOT;
                    FN_ADD: dec_alu_op = ALU_ADD;
                    FN_SUB: dec_alu_op = ALU_SUB;
                    FN_MOV: dec_path   = PATH_MOV;
                    default: begin               // Unknown function, no write
                        dec_reg_wr = 1'b0;
                        dec_path   = PATH_NONE;
                    end
                endcase
            end
            OP_LOAD: begin
                dec_reg_wr = 1'b1;
                dec_load   = 1'b1;
                dec_ppp    = PREC_ALL;  // Precision bits overlap the immediate
            end
            OP_STORE: dec_store = 1'b1;
            OP_BEZ:   dec_branch = 1'b1;
            OP_BNEZ: begin
                dec_branch = 1'b1;
                dec_nz     = 1'b1;
            end
            OP_NOP:  ;
            default: ;
        endcase
        // Store data and branch test come from the rd field
        ra1 = (dec_store || dec_branch) ? ifid_q.m.rd : ifid_q.r.ra;
        if (kill) begin
            dec_reg_wr = 1'b0;
            dec_load   = 1'b0;
            dec_store  = 1'b0;
            dec_branch = 1'b0;
        end
    end

    assign ra2    = ifid_q.r.rb;
    assign imm_id = ifid_q.m.imm;

    // ------------------------------
    // ID/EX control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.reg_wr    <= 1'b0;
            ctrl.load      <= 1'b0;
            ctrl.store     <= 1'b0;
            ctrl.is_branch <= 1'b0;
        end else if (!stall) begin
            ctrl.reg_wr    <= dec_reg_wr;
            ctrl.load      <= dec_load;
            ctrl.store     <= dec_store;
            ctrl.is_branch <= dec_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ctrl.rd        <= ifid_q.r.rd;
            ctrl.ppp       <= dec_ppp;
            ctrl.lane_w    <= ifid_q.r.lane_w;
            ctrl.alu_op    <= dec_alu_op;
            ctrl.path      <= dec_path;
            ctrl.branch_nz <= dec_nz;
            ctrl.rs_a      <= ra1;
            ctrl.rt_a      <= ra2;
        end
    end

    // Load stall must release so the load can retire
    a_stall_once: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall);
    a_ld_st_excl: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.load && ctrl.store));

endmodule

// ==== hw/pe_exec.sv ====
`timescale 1ns/1ps
`include "pe_cfg.svh"

module pe_exec import pe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [0:`PE_DATA_W-1] rd1,
    input  logic [0:`PE_DATA_W-1] rd2,
    input  logic [0:`PE_IMM_W-1]  imm_id,
    input  logic                  stall,
    input  logic                  taken,
    input  logic [0:`PE_DATA_W-1] data_in,
    output logic                  rs_zero,
    output logic [0:`PE_IMM_W-1]  imm,
    output logic [0:`PE_ADDR_W-1] data_addr,
    output logic [0:`PE_DATA_W-1] data_out,
    output logic                  mem_en,
    output logic                  mem_wr_en,
    ex_ctrl_if.exec               ex,
    wb_if.src                     wb
);

    logic [0:`PE_DATA_W-1] rs_q;      // ID/EX operands
    logic [0:`PE_DATA_W-1] rt_q;
    logic [0:`PE_IMM_W-1]  imm_q;
    logic [0:`PE_DATA_W-1] rs_fw;     // After WB forwarding
    logic [0:`PE_DATA_W-1] rt_fw;
    logic [0:`PE_DATA_W-1] alu_y;
    logic [0:`PE_DATA_W-1] result;
    logic                  wb_reg_wr_q;  // EX/WB register
    logic [0:`PE_REG_AW-1] wb_wa_q;
    logic [0:`PE_DATA_W-1] wb_wd_q;
    wr_prec_t              wb_ppp_q;
    logic [0:`PE_DATA_W-1] wb_mask;

    always_ff @(posedge clk) begin
        if (!stall) begin
            rs_q  <= rd1;
            rt_q  <= rd2;
            imm_q <= imm_id;
        end
    end

    // ------------------------------
    // WB to EX forwarding
    // ------------------------------
    assign wb_mask = wr_mask(wb_ppp_q);

    always_comb begin
        rs_fw = rs_q;
        rt_fw = rt_q;
        if (wb_reg_wr_q && wb_wa_q != '0 && ex.rs_a == wb_wa_q)
            rs_fw = (rs_q & ~wb_mask) | (wb_wd_q & wb_mask);
        if (wb_reg_wr_q && wb_wa_q != '0 && ex.rt_a == wb_wa_q)
            rt_fw = (rt_q & ~wb_mask) | (wb_wd_q & wb_mask);
    end

    assign rs_zero = (rs_fw == '0);  // Zero test for the branch decision in pe_ctrl
    assign imm     = imm_q;

    pe_vec_alu u_alu (
        .alu_op (ex.alu_op),
        .lane_w (ex.lane_w),
        .a      (rs_fw),
        .b      (rt_fw),
        .y      (alu_y)
    );

    always_comb begin
        case (ex.path)
            PATH_ALU: result = alu_y;
            PATH_MOV: result = rs_fw;
            default:  result = '0;
        endcase
        if (ex.load)
            result = data_in;  // Valid in the cycle after the stall
    end

    // Every address maps to data memory
    assign data_addr = {{(`PE_ADDR_W-`PE_IMM_W){1'b0}}, imm_q};
    assign data_out  = rs_fw;
    assign mem_en    = ex.store || (ex.load && stall);
    assign mem_wr_en = ex.store;

    // ------------------------------
    // EX/WB
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            wb_reg_wr_q <= 1'b0;
        else if (!stall)
            wb_reg_wr_q <= ex.reg_wr;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_wa_q  <= ex.rd;
            wb_wd_q  <= result;
            wb_ppp_q <= ex.ppp;
        end
    end

    assign wb.reg_wr = wb_reg_wr_q;
    assign wb.wa     = wb_wa_q;
    assign wb.wd     = wb_wd_q;
    assign wb.ppp    = wb_ppp_q;

    a_wr_has_en: assert property (@(posedge clk) disable iff (reset)
        mem_wr_en |-> mem_en);
    // The slot behind a taken branch reaches EX with no effect
    a_taken_squash: assert property (@(posedge clk) disable iff (reset)
        taken |=> !(ex.reg_wr || ex.load || ex.store || ex.is_branch));

endmodule

// ==== hw/pe_top.sv ====
`timescale 1ns/1ps
`include "pe_cfg.svh"

module pe_top (
    input  logic                  clk,
    input  logic                  reset,
    output logic [0:`PE_ADDR_W-1] instr_addr,
    input  logic [0:31]           instr,
    output logic [0:`PE_ADDR_W-1] data_addr,
    input  logic [0:`PE_DATA_W-1] data_in,
    output logic [0:`PE_DATA_W-1] data_out,
    output logic                  mem_en,
    output logic                  mem_wr_en
);

    logic [0:`PE_REG_AW-1] ra1;
    logic [0:`PE_REG_AW-1] ra2;
    logic [0:`PE_DATA_W-1] rd1;
    logic [0:`PE_DATA_W-1] rd2;
    logic [0:`PE_IMM_W-1]  imm_id;  // ID immediate
    logic [0:`PE_IMM_W-1]  imm;     // EX immediate, branch target
    logic                  rs_zero;
    logic                  stall;
    logic                  taken;

    wb_if      u_wb ();
    ex_ctrl_if u_ex ();

    pe_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .rs_zero    (rs_zero),
        .imm        (imm),
        .instr_addr (instr_addr),
        .ra1        (ra1),
        .ra2        (ra2),
        .imm_id     (imm_id),
        .stall      (stall),
        .taken      (taken),
        .ctrl       (u_ex.ctrl)
    );

    pe_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2),
        .wb    (u_wb.sink)
    );

    pe_exec u_exec (
        .clk       (clk),
        .reset     (reset),
        .rd1       (rd1),
        .rd2       (rd2),
        .imm_id    (imm_id),
        .stall     (stall),
        .taken     (taken),
        .data_in   (data_in),
        .rs_zero   (rs_zero),
        .imm       (imm),
        .data_addr (data_addr),
        .data_out  (data_out),
        .mem_en    (mem_en),
        .mem_wr_en (mem_wr_en),
        .ex        (u_ex.exec),
        .wb        (u_wb.src)
    );

endmodule

// ==== dv/tb_pe_programs.svh ====
`ifndef TB_PE_PROGRAMS_SVH
`define TB_PE_PROGRAMS_SVH

// ------------------------------
// Row builders
// ------------------------------
// Start a row with its name, the words at 0x10 and 0x11 and the expected word at 0x20
task automatic new_row(input string name, input logic [63:0] a, input logic [63:0] b,
                       input logic [63:0] exp);
    t_name[nrow] = name;
    t_a[nrow]    = a;
    t_b[nrow]    = b;
    t_exp[nrow]  = exp;
    for (int k = 0; k < PLEN; k++)
        t_prog[nrow][k] = NOP_W;  // Unused slots are nops
endtask

task automatic put(input int k, input logic [31:0] w);
    t_prog[nrow][k] = w;
endtask

// ld r1; ld r2; one R-type word; store of the given register
task automatic alu_row(input string name, input logic [63:0] a, input logic [63:0] b,
                       input logic [63:0] exp, input logic [31:0] op, input int st_reg);
    new_row(name, a, b, exp);
    put(0, ld(1, DATA_A));
    put(1, ld(2, DATA_B));
    put(2, op);
    put(3, st(st_reg, STORE_ADDR));
    nrow++;
endtask

// Shadow slots 3 and 4 store the marker in r2 and the target is word 6
task automatic branch_row(input string name, input logic [63:0] a, input logic [5:0] opc,
                          input logic [63:0] exp);
    new_row(name, a, 64'h0bad, exp);
    put(0, ld(1, DATA_A));
    put(1, ld(2, DATA_B));
    put(2, br(opc, 1, 6 * 4));
    put(3, st(2, STORE_ADDR));
    put(4, st(2, STORE_ADDR));
    put(5, st(2, STORE_ADDR));
    put(6, rop(3, 1, 0, 0, 0, FN_NOT));
    put(7, st(3, STORE_ADDR));
    nrow++;
endtask

// ------------------------------
// The table
// ------------------------------
task automatic build_table();
    nrow = 0;
    // Bitwise ops and MOV on the whole word
    alu_row("and", 64'hf0f0_f0f0_0f0f_0f0f, 64'hff00_ff00_ff00_ff00,
            64'hf000_f000_0f00_0f00, rop(3, 1, 2, 0, 0, FN_AND), 3);
    alu_row("or", 64'hf0f0_f0f0_0f0f_0f0f, 64'hff00_ff00_ff00_ff00,
            64'hfff0_fff0_ff0f_ff0f, rop(3, 1, 2, 0, 0, FN_OR), 3);
    alu_row("xor", 64'hf0f0_f0f0_0f0f_0f0f, 64'hff00_ff00_ff00_ff00,
            64'h0ff0_0ff0_f00f_f00f, rop(3, 1, 2, 0, 0, FN_XOR), 3);
    alu_row("not", 64'hf0f0_f0f0_0f0f_0f0f, 64'hff00_ff00_ff00_ff00,
            64'h0f0f_0f0f_f0f0_f0f0, rop(3, 1, 2, 0, 0, FN_NOT), 3);
    alu_row("mov", 64'hf0f0_f0f0_0f0f_0f0f, 64'hff00_ff00_ff00_ff00,
            64'hf0f0_f0f0_0f0f_0f0f, rop(3, 1, 2, 0, 0, FN_MOV), 3);
    // All ones plus 0x01 per byte with the carry cut at lane edges
    alu_row("add_b", 64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101,
            64'h0000_0000_0000_0000, rop(3, 1, 2, 0, 0, FN_ADD), 3);
    alu_row("add_h", 64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101,
            64'h0100_0100_0100_0100, rop(3, 1, 2, 0, 1, FN_ADD), 3);
    alu_row("add_w", 64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101,
            64'h0101_0100_0101_0100, rop(3, 1, 2, 0, 2, FN_ADD), 3);
    alu_row("add_d", 64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101,
            64'h0101_0101_0101_0100, rop(3, 1, 2, 0, 3, FN_ADD), 3);
    // Zero minus 0x01 per byte with the borrow cut at lane edges
    alu_row("sub_b", 64'h0, 64'h0101_0101_0101_0101,
            64'hffff_ffff_ffff_ffff, rop(3, 1, 2, 0, 0, FN_SUB), 3);
    alu_row("sub_h", 64'h0, 64'h0101_0101_0101_0101,
            64'hfeff_feff_feff_feff, rop(3, 1, 2, 0, 1, FN_SUB), 3);
    alu_row("sub_w", 64'h0, 64'h0101_0101_0101_0101,
            64'hfefe_feff_fefe_feff, rop(3, 1, 2, 0, 2, FN_SUB), 3);
    alu_row("sub_d", 64'h0, 64'h0101_0101_0101_0101,
            64'hfefe_fefe_fefe_feff, rop(3, 1, 2, 0, 3, FN_SUB), 3);
    // Partial MOV into preloaded r1 where lane 0 is the leftmost byte
    alu_row("prec_all", 64'h0011_2233_4455_6677, 64'h8899_aabb_ccdd_eeff,
            64'h8899_aabb_ccdd_eeff, rop(1, 2, 0, 0, 0, FN_MOV), 1);
    alu_row("prec_hi", 64'h0011_2233_4455_6677, 64'h8899_aabb_ccdd_eeff,
            64'h8899_aabb_4455_6677, rop(1, 2, 0, 1, 0, FN_MOV), 1);
    alu_row("prec_lo", 64'h0011_2233_4455_6677, 64'h8899_aabb_ccdd_eeff,
            64'h0011_2233_ccdd_eeff, rop(1, 2, 0, 2, 0, FN_MOV), 1);
    alu_row("prec_even", 64'h0011_2233_4455_6677, 64'h8899_aabb_ccdd_eeff,
            64'h8811_aa33_cc55_ee77, rop(1, 2, 0, 3, 0, FN_MOV), 1);
    alu_row("prec_odd", 64'h0011_2233_4455_6677, 64'h8899_aabb_ccdd_eeff,
            64'h0099_22bb_44dd_66ff, rop(1, 2, 0, 4, 0, FN_MOV), 1);
    alu_row("prec_none", 64'h0011_2233_4455_6677, 64'h8899_aabb_ccdd_eeff,
            64'h0011_2233_4455_6677, rop(1, 2, 0, 5, 0, FN_MOV), 1);
    alu_row("r0_write", 64'h5, 64'h3, 64'h0, rop(0, 1, 2, 0, 3, FN_ADD), 0);
    // Dependent chain (5 + 3) ^ 5 - (5 + 3)
    new_row("fwd_chain", 64'h5, 64'h3, 64'h5);
    put(0, ld(1, DATA_A));
    put(1, ld(2, DATA_B));
    put(2, rop(3, 1, 2, 0, 3, FN_ADD));
    put(3, rop(4, 3, 1, 0, 0, FN_XOR));
    put(4, rop(5, 4, 3, 0, 3, FN_SUB));  // r3 seen through the WB bypass in ID
    put(5, st(5, STORE_ADDR));
    nrow++;
    new_row("load_use", 64'hdead_beef_0123_4567, 64'h0, 64'hdead_beef_0123_4567);
    put(0, ld(1, DATA_A));
    put(1, st(1, STORE_ADDR));
    nrow++;
    // Taken branches land on NOT r1 and a fall-through stores the marker
    branch_row("bez_taken", 64'h0, OP_BEZ, 64'hffff_ffff_ffff_ffff);
    branch_row("bez_fall", 64'h7, OP_BEZ, 64'h0bad);
    branch_row("bnez_taken", 64'h7, OP_BNEZ, 64'hffff_ffff_ffff_fff8);
    branch_row("bnez_fall", 64'h0, OP_BNEZ, 64'h0bad);
endtask

`endif

// ==== dv/tb_pe_top.sv ====
`timescale 1ns/1ps

module tb_pe_top;

    localparam int NTEST = 26;
    localparam int PLEN  = 8;               // Program words per test
    localparam int DATA_A     = 'h10;       // Preload addresses
    localparam int DATA_B     = 'h11;
    localparam int STORE_ADDR = 'h20;       // Result word

    localparam logic [5:0] OP_R    = 6'b101010;
    localparam logic [5:0] OP_LD   = 6'b100000;
    localparam logic [5:0] OP_ST   = 6'b100001;
    localparam logic [5:0] OP_BEZ  = 6'b100010;
    localparam logic [5:0] OP_BNEZ = 6'b100011;
    localparam logic [5:0] OP_NOP  = 6'b111100;
    localparam logic [31:0] NOP_W  = {OP_NOP, 26'd0};

    localparam int FN_AND = 1;
    localparam int FN_OR  = 2;
    localparam int FN_XOR = 3;
    localparam int FN_NOT = 4;
    localparam int FN_MOV = 5;
    localparam int FN_ADD = 6;
    localparam int FN_SUB = 7;

    logic        clk;
    logic        reset;
    logic [31:0] instr_addr;
    logic [31:0] instr;
    logic [31:0] data_addr;
    logic [63:0] data_in = '0;
    logic [63:0] data_out;
    logic        mem_en;
    logic        mem_wr_en;

    logic [31:0] rom  [0:63];
    logic [63:0] dmem [0:255];
    int          store_cnt;     // Writes to the result address since reset
    logic [63:0] store_val;     // First of them

    string       t_name [0:NTEST-1];
    logic [31:0] t_prog [0:NTEST-1][0:PLEN-1];
    logic [63:0] t_a    [0:NTEST-1];
    logic [63:0] t_b    [0:NTEST-1];
    logic [63:0] t_exp  [0:NTEST-1];
    int          nrow;
    int          cur;
    int          pass_cnt;
    int          fail_cnt;

    pe_top u_pe_top (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_in    (data_in),
        .data_out   (data_out),
        .mem_en     (mem_en),
        .mem_wr_en  (mem_wr_en)
    );

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [31:0] rop(input int rd, input int ra, input int rb,
                                        input int prec, input int lane, input int fn);
        return {OP_R, rd[4:0], ra[4:0], rb[4:0], prec[2:0], lane[1:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] ld(input int rd, input int addr);
        return {OP_LD, rd[4:0], 5'd0, addr[15:0]};
    endfunction

    function automatic logic [31:0] st(input int rs, input int addr);
        return {OP_ST, rs[4:0], 5'd0, addr[15:0]};  // Source sits in the rd field
    endfunction

    function automatic logic [31:0] br(input logic [5:0] opc, input int rs, input int target);
        return {opc, rs[4:0], 5'd0, target[15:0]};
    endfunction

    `include "tb_pe_programs.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Memory models
    // ------------------------------
    assign instr = rom[instr_addr[7:2]];  // Combinational ROM

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= {8{i[7:0]}};  // Address in every byte
            dmem[DATA_A] <= t_a[cur];
            dmem[DATA_B] <= t_b[cur];
            store_cnt    <= 0;
        end else if (mem_wr_en === 1'b1) begin
            dmem[data_addr[7:0]] <= data_out;
            if (data_addr == STORE_ADDR && store_cnt == 0)
                store_val <= data_out;
            if (data_addr == STORE_ADDR)
                store_cnt <= store_cnt + 1;
        end
    end

    // Read data presented on the falling edge of the strobe cycle
    always @(negedge clk) begin
        if (mem_en === 1'b1 && mem_wr_en !== 1'b1)
            data_in <= dmem[data_addr[7:0]];
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            fail_cnt++;
        end else begin
            $display("PASS %s expected %h actual %h", name, exp, act);
            pass_cnt++;
        end
    endtask

    // ------------------------------
    // Test loop
    // ------------------------------
    initial begin
        reset    = 1'b1;
        cur      = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 0; i < 64; i++)
            rom[i] = NOP_W;
        build_table();
        for (int t = 0; t < nrow; t++) begin
            @(negedge clk);
            reset = 1'b1;
            cur   = t;
            for (int i = 0; i < 64; i++)
                rom[i] = (i < PLEN) ? t_prog[t][i] : NOP_W;
            repeat (10) @(negedge clk);  // Reset, memory preload
            reset = 1'b0;
            while (store_cnt == 0)
                @(negedge clk);
            check_value(t_name[t], t_exp[t], store_val);
        end
        $display("Done: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // 64 cycles budget per test
    initial begin
        #(NTEST * 64 * 40);
        $display("Timeout: test %s never wrote its result word", t_name[cur]);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
+incdir+dv
hw/pe_pkg.sv
hw/pe_if.sv
hw/pe_vec_alu.sv
hw/pe_regfile.sv
hw/pe_ctrl.sv
hw/pe_exec.sv
hw/pe_top.sv
dv/tb_pe_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_pe_top -o sim_pe > build.log 2>&1 &&
./obj_dir/sim_pe > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
